// ==== rename_pkg.sv ====
// rename types for architectural registers and physical tags
`default_nettype none

`include "rob_defines.svh"

package rename_pkg;

	// destination register as seen by the program
	typedef logic [`AR_BITS-1:0] arch_reg_t;

	// slot in the physical register file
	typedef logic [`PR_BITS-1:0] phys_reg_t;

	// one tag per completion lane, lane 0 in the low bits
	typedef phys_reg_t [`CDB_LANES-1:0] cdb_tag_vec_t;

endpackage

`default_nettype wire

// ==== rob_defines.svh ====
// rob sizing macros shared by the packages and the RTL blocks
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

////////////////////
// buffer geometry

`define ROB_DEPTH	16	// entries, kept a power of two
`define ROB_IDX_BITS	4	// log2 of the depth

////////////////////
// rename widths

`define PR_BITS	7	// physical register tag
`define AR_BITS	5	// architectural register number

////////////////////
// completion bus

`define CDB_LANES	4	// lanes broadcast per cycle

// tag held by a free entry, all ones so no live tag can hit it
`define EMPTY_TAG	{`PR_BITS{1'b1}}

`endif

// ==== rob_dispatch.sv ====
// rob dispatch side: tail pointer, occupancy count and capacity level
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_dispatch
(
	input wire clock,
	input wire reset,
	input wire rob_pkg::slot_count_t dispatch_num,	// entries written this cycle
	input wire rob_pkg::slot_count_t retire_num,	// entries leaving this cycle
	output rob_pkg::rob_idx_t tail,
	output rob_pkg::slot_count_t cap
);

	rob_pkg::occupancy_t occupancy;	// live entries
	rob_pkg::occupancy_t occupancy_next;
	rob_pkg::rob_idx_t tail_next;

	////////////////////
	// next state

	always_comb
	begin
		occupancy_next = occupancy
			+ rob_pkg::occupancy_t'(dispatch_num)
			- rob_pkg::occupancy_t'(retire_num);
		tail_next = tail + rob_pkg::rob_idx_t'(dispatch_num);	// wraps at depth
	end

	////////////////////
	// registers

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail <= '0;
			occupancy <= '0;	// ring starts empty
		end
		else
		begin
			tail <= tail_next;
			occupancy <= occupancy_next;
		end
	end

	////////////////////
	// capacity for next dispatch

	// dispatch may send at most what is free, capped at two
	always_comb
	begin
		if (occupancy == rob_pkg::occupancy_t'(`ROB_DEPTH))
		begin
			cap = 2'd0;	// full
		end
		else if (occupancy == rob_pkg::occupancy_t'(`ROB_DEPTH - 1))
		begin
			cap = 2'd1;	// one slot left
		end
		else
		begin
			cap = 2'd2;
		end
	end

endmodule

`default_nettype wire

// ==== rob_entries.sv ====
// rob entry storage with dispatch writes, completion tag match and retire clear
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_entries
(
	input wire clock,
	input wire reset,
	// dispatch
	input wire rob_pkg::rob_idx_t tail,
	input wire rob_pkg::slot_count_t dispatch_num,
	input wire rename_pkg::phys_reg_t new_tag_0,
	input wire rename_pkg::phys_reg_t new_tag_1,
	input wire rename_pkg::phys_reg_t old_tag_0,
	input wire rename_pkg::phys_reg_t old_tag_1,
	input wire rename_pkg::arch_reg_t dest_ar_0,
	input wire rename_pkg::arch_reg_t dest_ar_1,
	input wire inst_valid_0,
	input wire inst_valid_1,
	input wire inst_halt_0,
	input wire inst_halt_1,
	// completion bus
	input wire rob_pkg::cdb_lane_mask_t cdb_valid,
	input wire rename_pkg::cdb_tag_vec_t cdb_tags,
	input wire rob_pkg::cdb_lane_mask_t cdb_exception,
	// retire
	input wire rob_pkg::rob_idx_t head,
	input wire rob_pkg::slot_count_t retire_num,
	output logic head_ready,
	output logic next_ready,
	output logic head_exception,
	output logic next_exception,
	output logic head_halt,
	output logic next_halt,
	output rename_pkg::phys_reg_t retire_tag_a,
	output rename_pkg::phys_reg_t retire_tag_b,
	output rename_pkg::phys_reg_t retire_old_tag_a,
	output rename_pkg::phys_reg_t retire_old_tag_b,
	output rename_pkg::arch_reg_t retire_ar_a,
	output rename_pkg::arch_reg_t retire_ar_b
);

	// per entry status bits
	logic [`ROB_DEPTH-1:0] valid;
	logic [`ROB_DEPTH-1:0] ready;
	logic [`ROB_DEPTH-1:0] exception;
	logic [`ROB_DEPTH-1:0] halt;

	// per entry fields
	rename_pkg::phys_reg_t tag [`ROB_DEPTH];	// new physical tag
	rename_pkg::phys_reg_t old_tag [`ROB_DEPTH];	// tag freed at retire
	rename_pkg::arch_reg_t ar [`ROB_DEPTH];

	rob_pkg::rob_idx_t head_plus_one;
	rob_pkg::rob_idx_t tail_plus_one;

	logic [`ROB_DEPTH-1:0] cdb_hit;	// entry matched by some lane
	logic [`ROB_DEPTH-1:0] cdb_hit_exception;

	assign head_plus_one = head + rob_pkg::rob_idx_t'(1);	// wraps at depth
	assign tail_plus_one = tail + rob_pkg::rob_idx_t'(1);

	////////////////////
	// completion tag search

	// lanes never carry the same tag, so at most one lane hits an entry
	always_comb
	begin
		cdb_hit = '0;
		cdb_hit_exception = '0;
		for (int e = 0; e < `ROB_DEPTH; e++)
		begin
			for (int l = 0; l < `CDB_LANES; l++)
			begin
				if (cdb_valid[l] && valid[e] && (tag[e] == cdb_tags[l]))
				begin
					cdb_hit[e] = 1'b1;
					cdb_hit_exception[e] = cdb_hit_exception[e] | cdb_exception[l];
				end
			end
		end
	end

	////////////////////
	// status and tag update

	// retiring entries are ready and dispatch targets free ones,
	// so the three updates below never touch the same entry
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			ready <= '0;
			exception <= '0;
			halt <= '0;
			for (int e = 0; e < `ROB_DEPTH; e++)
			begin
				tag[e] <= `EMPTY_TAG;
			end
		end
		else
		begin
			// retire frees the head entries
			if (retire_num != 2'd0)
			begin
				valid[head] <= 1'b0;
				ready[head] <= 1'b0;
				tag[head] <= `EMPTY_TAG;
			end
			if (retire_num == 2'd2)
			begin
				valid[head_plus_one] <= 1'b0;
				ready[head_plus_one] <= 1'b0;
				tag[head_plus_one] <= `EMPTY_TAG;
			end
			for (int e = 0; e < `ROB_DEPTH; e++)
			begin
				if (cdb_hit[e])
				begin
					ready[e] <= 1'b1;
					exception[e] <= cdb_hit_exception[e];
				end
			end
			// bubbles and halts need no completion
			if (dispatch_num != 2'd0)
			begin
				valid[tail] <= 1'b1;
				ready[tail] <= ~inst_valid_0 | inst_halt_0;
				exception[tail] <= 1'b0;
				halt[tail] <= inst_halt_0;
				tag[tail] <= new_tag_0;
			end
			if (dispatch_num == 2'd2)
			begin
				valid[tail_plus_one] <= 1'b1;
				ready[tail_plus_one] <= ~inst_valid_1 | inst_halt_1;
				exception[tail_plus_one] <= 1'b0;
				halt[tail_plus_one] <= inst_halt_1;
				tag[tail_plus_one] <= new_tag_1;
			end
		end
	end

	// old tag and register written at dispatch
	always_ff @(posedge clock)
	begin
		if (dispatch_num != 2'd0)
		begin
			old_tag[tail] <= old_tag_0;
			ar[tail] <= dest_ar_0;
		end
		if (dispatch_num == 2'd2)
		begin
			old_tag[tail_plus_one] <= old_tag_1;
			ar[tail_plus_one] <= dest_ar_1;
		end
	end

	////////////////////
	// head window for retire

	assign head_ready = ready[head];
	assign next_ready = ready[head_plus_one];
	assign head_exception = exception[head];
	assign next_exception = exception[head_plus_one];
	assign head_halt = halt[head];
	assign next_halt = halt[head_plus_one];

	assign retire_tag_a = tag[head];
	assign retire_tag_b = tag[head_plus_one];
	assign retire_old_tag_a = old_tag[head];	// to free list
	assign retire_old_tag_b = old_tag[head_plus_one];
	assign retire_ar_a = ar[head];	// to map table
	assign retire_ar_b = ar[head_plus_one];

endmodule

`default_nettype wire

// ==== rob_pkg.sv ====
// reorder buffer bookkeeping types for indices, counts and lane masks
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

	// position of an entry in the ring
	typedef logic [`ROB_IDX_BITS-1:0] rob_idx_t;

	// 0, 1 or 2 entries
	// shared by dispatch count, retire count and capacity
	typedef logic [1:0] slot_count_t;

	// live entries, needs one bit more than the index to hold a full ring
	typedef logic [`ROB_IDX_BITS:0] occupancy_t;

	// one bit per completion lane
	typedef logic [`CDB_LANES-1:0] cdb_lane_mask_t;

endpackage

`default_nettype wire

// ==== rob_retire.sv ====
// rob retire control: head pointer, retire count and exception and halt pulses
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_retire
(
	input wire clock,
	input wire reset,
	input wire head_ready,
	input wire next_ready,	// entry at head plus one
	input wire head_exception,
	input wire next_exception,
	input wire head_halt,
	input wire next_halt,
	output rob_pkg::rob_idx_t head,
	output rob_pkg::slot_count_t retire_num,
	output logic recover_exception,
	output logic retire_halt
);

	logic retire_a;	// head leaves this cycle
	logic retire_b;	// head plus one leaves too

	////////////////////
	// retire decision

	// an excepting head retires alone so recovery starts right after it
	always_comb
	begin
		if (head_ready && next_ready && !head_exception)
		begin
			retire_num = 2'd2;
		end
		else if (head_ready)
		begin
			retire_num = 2'd1;
		end
		else
		begin
			retire_num = 2'd0;
		end
	end

	assign retire_a = (retire_num != 2'd0);
	assign retire_b = (retire_num == 2'd2);

	////////////////////
	// pulses

	assign recover_exception = (retire_a & head_exception) | (retire_b & next_exception);
	assign retire_halt = (retire_a & head_halt) | (retire_b & next_halt);

	// head moves by the retire count, wraps at depth
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
		end
		else
		begin
			head <= head + rob_pkg::rob_idx_t'(retire_num);
		end
	end

endmodule

`default_nettype wire

// ==== rob_tb.sv ====
// random-stimulus testbench for the two-wide reorder buffer with a queue model
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_tb;

	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int RUN_CYCLES = 2000;
	localparam int QUIET_CYCLES = 120;	// no completions so the ring fills up
	localparam int TIMEOUT_NS = RUN_CYCLES * CLOCK_PERIOD + 1000;

	typedef struct packed {
		rename_pkg::phys_reg_t tag;
		rename_pkg::phys_reg_t old_tag;
		rename_pkg::arch_reg_t ar;
		logic valid;	// real instruction rather than a bubble
		logic halt;
		logic ready;
		logic exception;
	} model_entry_t;

	logic clock;
	logic reset;
	rob_pkg::slot_count_t dispatch_num;
	rename_pkg::phys_reg_t new_tag_0;
	rename_pkg::phys_reg_t new_tag_1;
	rename_pkg::phys_reg_t old_tag_0;
	rename_pkg::phys_reg_t old_tag_1;
	rename_pkg::arch_reg_t dest_ar_0;
	rename_pkg::arch_reg_t dest_ar_1;
	logic inst_valid_0;
	logic inst_valid_1;
	logic inst_halt_0;
	logic inst_halt_1;
	rob_pkg::cdb_lane_mask_t cdb_valid;
	rename_pkg::cdb_tag_vec_t cdb_tags;
	rob_pkg::cdb_lane_mask_t cdb_exception;
	wire rob_pkg::slot_count_t cap;
	wire rob_pkg::slot_count_t retire_num;
	wire rename_pkg::phys_reg_t retire_tag_a;
	wire rename_pkg::phys_reg_t retire_tag_b;
	wire rename_pkg::phys_reg_t retire_old_tag_a;
	wire rename_pkg::phys_reg_t retire_old_tag_b;
	wire rename_pkg::arch_reg_t retire_ar_a;
	wire rename_pkg::arch_reg_t retire_ar_b;
	wire recover_exception;
	wire retire_halt;

	int seed;
	model_entry_t model_q[$];	// oldest entry at index 0
	rename_pkg::phys_reg_t tag_pool[$];	// free physical tags
	int dual_count;
	int recover_count;
	int slot_b_recover_count;
	int halt_count;
	logic cap_one_seen;
	logic cap_zero_seen;

	rob_top i_dut
	(
		.clock(clock), .reset(reset), .dispatch_num(dispatch_num),
		.new_tag_0(new_tag_0), .new_tag_1(new_tag_1),
		.old_tag_0(old_tag_0), .old_tag_1(old_tag_1),
		.dest_ar_0(dest_ar_0), .dest_ar_1(dest_ar_1),
		.inst_valid_0(inst_valid_0), .inst_valid_1(inst_valid_1),
		.inst_halt_0(inst_halt_0), .inst_halt_1(inst_halt_1),
		.cdb_valid(cdb_valid), .cdb_tags(cdb_tags), .cdb_exception(cdb_exception),
		.cap(cap), .retire_num(retire_num),
		.retire_tag_a(retire_tag_a), .retire_tag_b(retire_tag_b),
		.retire_old_tag_a(retire_old_tag_a), .retire_old_tag_b(retire_old_tag_b),
		.retire_ar_a(retire_ar_a), .retire_ar_b(retire_ar_b),
		.recover_exception(recover_exception), .retire_halt(retire_halt)
	);

	initial clock = 1'b0;
	always #(CLOCK_PERIOD / 2) clock = ~clock;

	////////////////////
	// reporting

	task automatic stop_on_error(string line);
		$display("%s", line);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic expect_equal(string what, logic [31:0] got, logic [31:0] expected);
		assert (got === expected)
		else stop_on_error($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d",
			$time, what, got, expected));
	endtask

	// hang guard sized from the run length
	initial
	begin
		#(TIMEOUT_NS);
		stop_on_error("watchdog expired before the test sequence finished");
	end

	////////////////////
	// model

	function automatic int unsigned rand_below(int unsigned n);
		rand_below = {$random(seed)} % n;
	endfunction

	function automatic int expected_cap();
		if (model_q.size() == `ROB_DEPTH)
			expected_cap = 0;
		else if (model_q.size() == `ROB_DEPTH - 1)
			expected_cap = 1;
		else
			expected_cap = 2;
	endfunction

	function automatic int expected_retire_count();
		expected_retire_count = 0;
		if (model_q.size() >= 1 && model_q[0].ready)
		begin
			expected_retire_count = 1;
			if (model_q.size() >= 2 && model_q[1].ready && !model_q[0].exception)
				expected_retire_count = 2;
		end
	endfunction

	function automatic model_entry_t random_entry();
		model_entry_t e;
		e.tag = `EMPTY_TAG;	// filled from the pool when dispatched
		e.old_tag = rename_pkg::phys_reg_t'(rand_below(1 << `PR_BITS));
		e.ar = rename_pkg::arch_reg_t'(rand_below(1 << `AR_BITS));
		e.valid = 1'b1;
		e.halt = 1'b0;
		e.exception = 1'b0;
		if (rand_below(40) == 0)
			e.halt = 1'b1;
		else if (rand_below(8) == 0)
			e.valid = 1'b0;
		e.ready = !e.valid || e.halt;	// no completion needed
		random_entry = e;
	endfunction

	task automatic check_outputs();
		int exp_num;
		logic exp_recover;
		logic exp_halt;
		exp_num = expected_retire_count();
		exp_recover = 1'b0;
		exp_halt = 1'b0;
		expect_equal("cap", cap, expected_cap());
		expect_equal("retire_num", retire_num, exp_num);
		if (exp_num >= 1)
		begin
			expect_equal("retire_tag_a", retire_tag_a, model_q[0].tag);
			expect_equal("retire_old_tag_a", retire_old_tag_a, model_q[0].old_tag);
			expect_equal("retire_ar_a", retire_ar_a, model_q[0].ar);
			exp_recover = model_q[0].exception;
			exp_halt = model_q[0].halt;
		end
		if (exp_num == 2)
		begin
			expect_equal("retire_tag_b", retire_tag_b, model_q[1].tag);
			expect_equal("retire_old_tag_b", retire_old_tag_b, model_q[1].old_tag);
			expect_equal("retire_ar_b", retire_ar_b, model_q[1].ar);
			exp_recover = exp_recover | model_q[1].exception;	// slot b can recover
			exp_halt = exp_halt | model_q[1].halt;
			dual_count++;
			if (model_q[1].exception)
				slot_b_recover_count++;
		end
		expect_equal("recover_exception", recover_exception, exp_recover);
		expect_equal("retire_halt", retire_halt, exp_halt);
		if (exp_recover)
			recover_count++;
		if (exp_halt)
			halt_count++;
	endtask

	// retired tags go to the back of the pool, so reuse is delayed
	task automatic retire_model();
		int n;
		model_entry_t e;
		n = expected_retire_count();
		repeat (n)
		begin
			e = model_q.pop_front();
			tag_pool.push_back(e.tag);
		end
	endtask

	task automatic complete_random(logic enable);
		int cands[$];
		int j;
		int idx;
		model_entry_t e;
		cdb_valid = '0;
		cdb_tags = '0;
		cdb_exception = '0;
		for (int i = 0; i < model_q.size(); i++)
			if (!model_q[i].ready)
				cands.push_back(i);
		for (int l = 0; l < `CDB_LANES; l++)
		begin
			if (enable && cands.size() > 0 && rand_below(2) == 0)
			begin
				j = rand_below(cands.size());
				idx = cands[j];
				cands.delete(j);
				e = model_q[idx];
				e.ready = 1'b1;
				e.exception = (rand_below(12) == 0);
				model_q[idx] = e;
				cdb_valid[l] = 1'b1;
				cdb_tags[l] = e.tag;
				cdb_exception[l] = e.exception;
			end
		end
	endtask

	task automatic dispatch_random(int cap_now);
		int n;
		model_entry_t e0;
		model_entry_t e1;
		n = rand_below(cap_now + 1);
		e0 = random_entry();
		e1 = random_entry();
		if (n >= 1)
		begin
			e0.tag = tag_pool.pop_front();
			model_q.push_back(e0);
		end
		if (n == 2)
		begin
			e1.tag = tag_pool.pop_front();
			model_q.push_back(e1);
		end
		dispatch_num = rob_pkg::slot_count_t'(n);
		new_tag_0 = e0.tag;
		old_tag_0 = e0.old_tag;
		dest_ar_0 = e0.ar;
		inst_valid_0 = e0.valid;
		inst_halt_0 = e0.halt;
		new_tag_1 = e1.tag;
		old_tag_1 = e1.old_tag;
		dest_ar_1 = e1.ar;
		inst_valid_1 = e1.valid;
		inst_halt_1 = e1.halt;
	endtask

	////////////////////
	// main sequence

	initial
	begin
		int cap_now;
		seed = 12198;
		reset = 1'b1;
		dispatch_num = '0;
		{new_tag_0, new_tag_1, old_tag_0, old_tag_1} = '0;
		{dest_ar_0, dest_ar_1} = '0;
		{inst_valid_0, inst_valid_1, inst_halt_0, inst_halt_1} = '0;
		cdb_valid = '0;
		cdb_tags = '0;
		cdb_exception = '0;
		{dual_count, recover_count, slot_b_recover_count, halt_count} = '0;
		cap_one_seen = 1'b0;
		cap_zero_seen = 1'b0;
		for (int t = 0; t < (1 << `PR_BITS) - 1; t++)
			tag_pool.push_back(rename_pkg::phys_reg_t'(t));	// all but the empty tag
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		expect_equal("cap after reset", cap, 2);
		expect_equal("retire_num after reset", retire_num, 0);
		expect_equal("recover_exception after reset", recover_exception, 0);
		expect_equal("retire_halt after reset", retire_halt, 0);
		for (int cycle = 0; cycle < RUN_CYCLES; cycle++)
		begin
			cap_now = expected_cap();
			check_outputs();
			if (cycle < QUIET_CYCLES && cap == 2'd1)
				cap_one_seen = 1'b1;
			if (cycle < QUIET_CYCLES && cap == 2'd0 && cap_one_seen)
				cap_zero_seen = 1'b1;
			retire_model();
			complete_random(cycle >= QUIET_CYCLES);
			// one entry per cycle while filling, so the ring passes through cap 1
			if (cycle < QUIET_CYCLES && cap_now > 1)
				dispatch_random(1);
			else
				dispatch_random(cap_now);
			@(posedge clock);
			#1;	// drive and sample just after the edge
		end
		$display("dual %0d, recover %0d (slot b %0d), halt %0d",
			dual_count, recover_count, slot_b_recover_count, halt_count);
		assert (cap_one_seen && cap_zero_seen)
		else stop_on_error("the buffer never filled to cap 1 and then cap 0");
		assert (dual_count > 0 && recover_count > 0 && slot_b_recover_count > 0
			&& halt_count > 0)
		else stop_on_error("dual retire, recovery, slot b recovery or halt was never exercised");
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rob_top.sv ====
// two-wide reorder buffer top, joins the dispatch, entry and retire blocks
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_top
(
	input wire clock,
	input wire reset,
	// dispatch stage
	input wire rob_pkg::slot_count_t dispatch_num,	// never above cap
	input wire rename_pkg::phys_reg_t new_tag_0,
	input wire rename_pkg::phys_reg_t new_tag_1,
	input wire rename_pkg::phys_reg_t old_tag_0,
	input wire rename_pkg::phys_reg_t old_tag_1,
	input wire rename_pkg::arch_reg_t dest_ar_0,
	input wire rename_pkg::arch_reg_t dest_ar_1,
	input wire inst_valid_0,
	input wire inst_valid_1,
	input wire inst_halt_0,
	input wire inst_halt_1,
	// completion bus
	input wire rob_pkg::cdb_lane_mask_t cdb_valid,
	input wire rename_pkg::cdb_tag_vec_t cdb_tags,
	input wire rob_pkg::cdb_lane_mask_t cdb_exception,
	// to dispatch stage
	output wire rob_pkg::slot_count_t cap,
	// to map table and free list
	output wire rob_pkg::slot_count_t retire_num,
	output wire rename_pkg::phys_reg_t retire_tag_a,
	output wire rename_pkg::phys_reg_t retire_tag_b,
	output wire rename_pkg::phys_reg_t retire_old_tag_a,
	output wire rename_pkg::phys_reg_t retire_old_tag_b,
	output wire rename_pkg::arch_reg_t retire_ar_a,
	output wire rename_pkg::arch_reg_t retire_ar_b,
	output wire recover_exception,
	output wire retire_halt
);

	wire rob_pkg::rob_idx_t tail;
	wire rob_pkg::rob_idx_t head;

	// head window status
	wire head_ready;
	wire next_ready;
	wire head_exception;
	wire next_exception;
	wire head_halt;
	wire next_halt;

	rob_dispatch i_dispatch
	(
		.clock(clock),
		.reset(reset),
		.dispatch_num(dispatch_num),
		.retire_num(retire_num),
		.tail(tail),
		.cap(cap)
	);

	rob_entries i_entries
	(
		.clock(clock),
		.reset(reset),
		.tail(tail),
		.dispatch_num(dispatch_num),
		.new_tag_0(new_tag_0),
		.new_tag_1(new_tag_1),
		.old_tag_0(old_tag_0),
		.old_tag_1(old_tag_1),
		.dest_ar_0(dest_ar_0),
		.dest_ar_1(dest_ar_1),
		.inst_valid_0(inst_valid_0),
		.inst_valid_1(inst_valid_1),
		.inst_halt_0(inst_halt_0),
		.inst_halt_1(inst_halt_1),
		.cdb_valid(cdb_valid),
		.cdb_tags(cdb_tags),
		.cdb_exception(cdb_exception),
		.head(head),
		.retire_num(retire_num),
		.head_ready(head_ready),
		.next_ready(next_ready),
		.head_exception(head_exception),
		.next_exception(next_exception),
		.head_halt(head_halt),
		.next_halt(next_halt),
		.retire_tag_a(retire_tag_a),
		.retire_tag_b(retire_tag_b),
		.retire_old_tag_a(retire_old_tag_a),
		.retire_old_tag_b(retire_old_tag_b),
		.retire_ar_a(retire_ar_a),
		.retire_ar_b(retire_ar_b)
	);

	rob_retire i_retire
	(
		.clock(clock),
		.reset(reset),
		.head_ready(head_ready),
		.next_ready(next_ready),
		.head_exception(head_exception),
		.next_exception(next_exception),
		.head_halt(head_halt),
		.next_halt(next_halt),
		.head(head),
		.retire_num(retire_num),
		.recover_exception(recover_exception),
		.retire_halt(retire_halt)
	);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
rename_pkg.sv
rob_pkg.sv
rob_dispatch.sv
rob_entries.sv
rob_retire.sv
rob_top.sv
rob_tb.sv
